//--- include/char_params.svh
//####################################################################
// Video geometry, character RAM size and table bases for the text layer
// Include wherever one of these constants is needed
//####################################################################
`ifndef CHAR_PARAMS_SVH
`define CHAR_PARAMS_SVH

`define CHAR_VRAM_AW      11      // 2K words of 16 bits
`define CHAR_H_TOTAL      384     // Pixels per line incl. blanking
`define CHAR_V_TOTAL      262     // Lines per frame
`define CHAR_H_ACTIVE     320
`define CHAR_V_ACTIVE     224
`define CHAR_ROW_SLOT     8       // hdump[8:4] of the row scroll read
`define CHAR_ROWSCR_BASE  5'h1f   // Top address bits of row scroll table
`define CHAR_COLSCR_BASE  5'h1e   // Top address bits of column scroll table
`define CHAR_PXL_LAG      16      // Tile fetch to pixel output, in pixels
`define CHAR_FLIP_OFFSET  9'ha3   // Horizontal position reflection

`endif

//--- hdl/video_pkg.sv
//####################################################################
// Video side types shared by the scan engine and the top level
// Import where a line slot or a pixel word is handled
//####################################################################
`default_nettype none

package video_pkg;

    // What the scan engine reads from the RAM in a pixel
    typedef enum logic [1:0] {
        SLOT_TILE   = 2'd0,
        SLOT_ROWSCR = 2'd1,
        SLOT_COLSCR = 2'd2
    } line_slot_t;

    // Character pixel word, attribute bits on top
    typedef struct packed {
        logic       prio;      // Priority over the background
        logic [2:0] pal;       // Palette select
        logic [2:0] colour;    // One bit from each plane
    } char_pxl_t;

endpackage

`default_nettype wire

//--- hdl/vram_bus_pkg.sv
//####################################################################
// Types for the shared character RAM bus
// Used by the CPU port and the arbiter
//####################################################################
`default_nettype none

package vram_bus_pkg;

    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1
    } vram_op_t;

    // Owner of the last RAM cycle
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_VIDEO = 2'd1,
        ARB_CPU   = 2'd2
    } arb_state_t;

endpackage

`default_nettype wire

//--- hdl/video_timing.sv
//####################################################################
// Pixel enables plus horizontal and vertical counters
// clk runs at four times the pixel rate
//####################################################################
`timescale 1ns/10ps
`default_nettype none
`include "char_params.svh"

module video_timing (
    input  wire        clk,
    input  wire        rst,
    output logic       pxl2_cen,
    output logic       pxl_cen,
    output logic [8:0] hdump,
    output logic [8:0] vdump,
    output logic [8:0] vrender,
    output logic       hblank
);
    logic [1:0] phase;    // Clock position within a pixel

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= 2'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            phase    <= phase + 2'd1;
            pxl2_cen <= phase[0];          // Every 2nd clock
            pxl_cen  <= phase == 2'd3;     // Every 4th clock
        end
    end

    // Counters step once per pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= 9'd0;
            vdump <= 9'd0;
        end else if (pxl_cen) begin
            if (hdump == 9'(`CHAR_H_TOTAL - 1)) begin
                hdump <= 9'd0;
                if (vdump == 9'(`CHAR_V_TOTAL - 1))
                    vdump <= 9'd0;         // New frame
                else
                    vdump <= vdump + 9'd1;
            end else begin
                hdump <= hdump + 9'd1;
            end
        end
    end

    // Line being prepared for the next scan
    assign vrender = (vdump == 9'(`CHAR_V_TOTAL - 1)) ? 9'd0 : vdump + 9'd1;
    assign hblank  = hdump >= 9'(`CHAR_H_ACTIVE);

endmodule

`default_nettype wire

//--- hdl/char_vram.sv
//####################################################################
// Single port character RAM with byte lanes and registered read
// Holds the tile map and both scroll tables
//####################################################################
`timescale 1ns/10ps
`default_nettype none
`include "char_params.svh"

module char_vram (
    input  wire                       clk,
    input  wire  [`CHAR_VRAM_AW-1:0]  ram_addr,
    input  wire  [15:0]               ram_wdata,
    input  wire  [1:0]                ram_we,
    output logic [15:0]               ram_q
);
    // Rows 0 to 27 tile map, row 30 column scroll, row 31 row scroll
    logic [15:0] mem [0:(1 << `CHAR_VRAM_AW) - 1];

    always_ff @(posedge clk) begin
        if (ram_we[0])
            mem[ram_addr][7:0] <= ram_wdata[7:0];
        if (ram_we[1])
            mem[ram_addr][15:8] <= ram_wdata[15:8];
        ram_q <= mem[ram_addr];    // Old data on a write cycle
    end

endmodule

`default_nettype wire

//--- hdl/vram_arbiter.sv
//####################################################################
// Shares the character RAM between the scan engine and the CPU port
// Scan reads always win, the CPU waits for a free clock
//####################################################################
`timescale 1ns/10ps
`default_nettype none
`include "char_params.svh"

module vram_arbiter (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          scan_req,
    input  wire  [`CHAR_VRAM_AW-1:0]     scan_addr,
    input  wire  video_pkg::line_slot_t  scan_slot,
    input  wire                          cpu_req,
    input  wire  vram_bus_pkg::vram_op_t cpu_op,
    input  wire  [`CHAR_VRAM_AW-1:0]     cpu_addr,
    input  wire  [15:0]                  cpu_wdata,
    input  wire  [1:0]                   cpu_be,
    output logic                         cpu_gnt,
    output logic [`CHAR_VRAM_AW-1:0]     ram_addr,
    output logic [15:0]                  ram_wdata,
    output logic [1:0]                   ram_we
);
    import vram_bus_pkg::*;
    import video_pkg::*;

    arb_state_t state;    // Who owns the data coming back now

    // No grant right after a CPU cycle so one request gets one grant
    assign cpu_gnt   = cpu_req && !scan_req && state != ARB_CPU;
    assign ram_addr  = scan_req ? scan_addr : cpu_addr;
    assign ram_wdata = cpu_wdata;
    assign ram_we    = (cpu_gnt && cpu_op == OP_WRITE) ? cpu_be : 2'b00;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= ARB_IDLE;
        else if (scan_req)
            state <= ARB_VIDEO;
        else if (cpu_gnt)
            state <= ARB_CPU;
        else
            state <= ARB_IDLE;
    end

    a_no_gnt_on_scan: assert property (@(posedge clk) disable iff (rst)
        scan_req |-> !cpu_gnt);
    a_scan_read_only: assert property (@(posedge clk) disable iff (rst)
        scan_req |-> ram_we == 2'b00);
    // Scroll slots must land inside the scroll tables of the RAM map
    a_scroll_addr: assert property (@(posedge clk) disable iff (rst)
        (scan_req && scan_slot != SLOT_TILE) |->
        scan_addr[10:6] inside {`CHAR_ROWSCR_BASE, `CHAR_COLSCR_BASE});

endmodule

`default_nettype wire

//--- hdl/cpu_vram_port.sv
//####################################################################
// CPU side of the character RAM
// Holds an access until granted and ends it with one ok pulse
//####################################################################
`timescale 1ns/10ps
`default_nettype none
`include "char_params.svh"

module cpu_vram_port (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           char_cs,
    input  wire  [11:1]                   addr,
    input  wire  [15:0]                   din,
    input  wire  [1:0]                    dsn,
    output logic [15:0]                   dout,
    output logic                          ok,
    output logic                          cpu_req,
    output vram_bus_pkg::vram_op_t        cpu_op,
    output logic [`CHAR_VRAM_AW-1:0]      cpu_addr,
    output logic [15:0]                   cpu_wdata,
    output logic [1:0]                    cpu_be,
    input  wire                           cpu_gnt,
    input  wire  [15:0]                   ram_q
);
    import vram_bus_pkg::*;

    logic       done;       // Served, waits for char_cs low
    logic       wr_flag;
    arb_state_t owner;      // ARB_CPU while read data returns

    assign wr_flag   = dsn != 2'b11;    // Any lane strobe means write
    assign cpu_op    = wr_flag ? OP_WRITE : OP_READ;
    assign cpu_req   = char_cs && !done;
    assign cpu_addr  = addr;
    assign cpu_wdata = din;
    assign cpu_be    = ~dsn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done  <= 1'b0;
            ok    <= 1'b0;
            owner <= ARB_IDLE;
        end else begin
            ok    <= cpu_gnt && cpu_op == OP_WRITE;    // Write done at grant
            owner <= (cpu_gnt && cpu_op == OP_READ) ? ARB_CPU : ARB_IDLE;
            if (owner == ARB_CPU)
                ok <= 1'b1;                          // Read data captured
            if (!char_cs)
                done <= 1'b0;
            else if (cpu_gnt)
                done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (owner == ARB_CPU)
            dout <= ram_q;
    end

    // A waiting request holds still and no read is in flight
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (cpu_req && !cpu_gnt) |=>
        cpu_req && $stable(cpu_addr) && $stable(cpu_op) && owner == ARB_IDLE);

endmodule

`default_nettype wire

//--- hdl/char_scan.sv
//####################################################################
// Character scan engine
// Reads scroll tables in fixed slots, fetches tiles ahead of the beam
// and shifts out three bitplanes with their attribute
//####################################################################
`timescale 1ns/10ps
`default_nettype none
`include "char_params.svh"

module char_scan (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         pxl_cen,
    input  wire                         flip,
    input  wire  [8:0]                  hdump,
    input  wire  [8:0]                  vdump,
    input  wire  [8:0]                  vrender,
    input  wire  [8:0]                  scr1_hscan,
    input  wire  [8:0]                  scr2_hscan,
    input  wire  [15:0]                 vram_dout,
    input  wire  [23:0]                 rom_data,
    output logic                        scan_req,
    output logic [`CHAR_VRAM_AW-1:0]    scan_addr,
    output video_pkg::line_slot_t       scan_slot,
    output logic [12:0]                 rom_addr,
    output logic                        scr_start,
    output logic [9:0]                  rowscr1,
    output logic [9:0]                  rowscr2,
    output logic [8:0]                  colscr1,
    output logic [8:0]                  colscr2,
    output logic                        col_busy1,
    output logic                        col_busy2,
    output video_pkg::char_pxl_t        pxl
);
    import video_pkg::*;

    localparam logic [4:0] ROW_SLOT = 5'(`CHAR_ROW_SLOT);
    localparam logic [5:0] AHEAD    = 6'(`CHAR_PXL_LAG / 8);  // Tiles ahead

    logic [8:0]  vf, vfr, hf;     // Flipped coordinates
    logic [8:0]  hscan_mux;       // Next column of the layer in turn
    logic        row_rd, col_rd;
    logic        rd_l;            // RAM data valid this clock
    line_slot_t  slot_l;
    logic        lay_l;           // Layer of the returning read
    logic [15:0] scan;            // Last tile map entry
    logic [8:0]  code;
    logic [3:0]  attr0, attr;
    logic [23:0] pxl_data;        // Three planes of 8 pixels

    function automatic logic [7:0] plane_shift(input logic [7:0] plane,
                                               input logic right);
        return right ? plane >> 1 : plane << 1;
    endfunction

    always_ff @(posedge clk) begin
        vf  <= flip ? 9'(`CHAR_V_ACTIVE - 1) - vdump : vdump;
        vfr <= flip ? 9'(`CHAR_V_ACTIVE - 1) - vrender : vrender;  // Scroll line
        hf  <= flip ? `CHAR_FLIP_OFFSET - hdump : hdump;
    end

    assign hscan_mux = (hdump[0] ? scr2_hscan : scr1_hscan) + 9'd1;
    assign row_rd    = hdump[8:4] == ROW_SLOT && hdump[2:0] >= 3'd6;
    assign col_rd    = hdump[2:0] < 3'd6;
    assign scan_req  = pxl_cen;               // One read per pixel
    // One clock pulse, both row scroll entries already latched
    assign scr_start = pxl_cen && hdump == {ROW_SLOT + 5'd1, 4'd0};
    assign rom_addr  = {code, vf[2:0], 1'b0};

    always_comb begin
        scan_slot = SLOT_TILE;
        scan_addr = {vf[7:3], hf[8:3] + AHEAD};
        if (row_rd) begin
            scan_slot = SLOT_ROWSCR;
            scan_addr = {`CHAR_ROWSCR_BASE, vfr[7:3], hdump[3]};
        end else if (col_rd) begin
            scan_slot = SLOT_COLSCR;
            scan_addr = {`CHAR_COLSCR_BASE, hscan_mux[8:4], hdump[0]};
        end
    end

    // Scroll entries land one clock after the read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_l      <= 1'b0;
            slot_l    <= SLOT_TILE;
            lay_l     <= 1'b0;
            rowscr1   <= 10'd0;
            rowscr2   <= 10'd0;
            colscr1   <= 9'd0;
            colscr2   <= 9'd0;
            col_busy1 <= 1'b0;
            col_busy2 <= 1'b0;
        end else begin
            rd_l <= scan_req;
            if (scan_req) begin
                slot_l <= scan_slot;
                lay_l  <= row_rd ? hdump[3] : hdump[0];
            end
            col_busy1 <= rd_l && slot_l == SLOT_COLSCR && !lay_l;
            col_busy2 <= rd_l && slot_l == SLOT_COLSCR && lay_l;
            if (rd_l && slot_l == SLOT_ROWSCR) begin
                if (!lay_l)
                    rowscr1 <= vram_dout[9:0];
                else
                    rowscr2 <= vram_dout[9:0];
            end
            if (rd_l && slot_l == SLOT_COLSCR) begin
                if (!lay_l)
                    colscr1 <= vram_dout[8:0];
                else
                    colscr2 <= vram_dout[8:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_l && slot_l == SLOT_TILE)
            scan <= vram_dout;
    end

    // Code, then ROM data a tile later, attribute kept in step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            code     <= 9'd0;
            attr0    <= 4'd0;
            attr     <= 4'd0;
            pxl_data <= 24'd0;
        end else if (pxl_cen) begin
            if (hdump[2:0] == 3'd7) begin
                code     <= {1'b0, scan[7:0]};
                attr0    <= scan[11:8];
                attr     <= attr0;
                pxl_data <= rom_data;
            end else begin
                pxl_data[23:16] <= plane_shift(pxl_data[23:16], flip);
                pxl_data[15:8]  <= plane_shift(pxl_data[15:8], flip);
                pxl_data[7:0]   <= plane_shift(pxl_data[7:0], flip);
            end
        end
    end

    assign pxl.prio   = attr[3];
    assign pxl.pal    = attr[2:0];
    assign pxl.colour = flip ? {pxl_data[16], pxl_data[8], pxl_data[0]}
                             : {pxl_data[23], pxl_data[15], pxl_data[7]};

    a_one_scroll_slot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({row_rd, col_rd}));

endmodule

`default_nettype wire

//--- hdl/char_subsys_top.sv
//####################################################################
// Character layer subsystem top
// Timing, RAM, arbiter, CPU port and scan engine wired together
//####################################################################
`timescale 1ns/10ps
`default_nettype none
`include "char_params.svh"

module char_subsys_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    char_cs,
    input  wire  [11:1]            addr,
    input  wire  [15:0]            din,
    input  wire  [1:0]             dsn,
    output logic [15:0]            dout,
    output logic                   ok,
    input  wire                    flip,
    input  wire  [8:0]             scr1_hscan,
    input  wire  [8:0]             scr2_hscan,
    output logic [12:0]            rom_addr,
    input  wire  [23:0]            rom_data,
    output logic [8:0]             hdump,
    output logic [8:0]             vdump,
    output video_pkg::char_pxl_t   pxl,
    output logic                   scr_start,
    output logic [9:0]             rowscr1,
    output logic [9:0]             rowscr2,
    output logic [8:0]             colscr1,
    output logic [8:0]             colscr2,
    output logic                   col_busy1,
    output logic                   col_busy2,
    output logic                   hblank
);
    import video_pkg::*;
    import vram_bus_pkg::*;

    logic                     pxl_cen;
    logic [8:0]               vrender;
    logic                     scan_req;
    logic [`CHAR_VRAM_AW-1:0] scan_addr;
    line_slot_t               scan_slot;
    logic                     cpu_req, cpu_gnt;
    vram_op_t                 cpu_op;
    logic [`CHAR_VRAM_AW-1:0] cpu_addr, ram_addr;
    logic [15:0]              cpu_wdata, ram_wdata, ram_q;
    logic [1:0]               cpu_be, ram_we;

    video_timing video_timing_i (
        .clk(clk), .rst(rst),
        .pxl2_cen(), .pxl_cen(pxl_cen),         // 2x enable not needed here
        .hdump(hdump), .vdump(vdump), .vrender(vrender), .hblank(hblank)
    );

    char_vram char_vram_i (
        .clk(clk), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .ram_we(ram_we), .ram_q(ram_q)
    );

    vram_arbiter vram_arbiter_i (
        .clk(clk), .rst(rst),
        .scan_req(scan_req), .scan_addr(scan_addr), .scan_slot(scan_slot),
        .cpu_req(cpu_req), .cpu_op(cpu_op), .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata), .cpu_be(cpu_be), .cpu_gnt(cpu_gnt),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we)
    );

    cpu_vram_port cpu_vram_port_i (
        .clk(clk), .rst(rst),
        .char_cs(char_cs), .addr(addr), .din(din), .dsn(dsn),
        .dout(dout), .ok(ok),
        .cpu_req(cpu_req), .cpu_op(cpu_op), .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata), .cpu_be(cpu_be), .cpu_gnt(cpu_gnt),
        .ram_q(ram_q)
    );

    char_scan char_scan_i (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .flip(flip),
        .hdump(hdump), .vdump(vdump), .vrender(vrender),
        .scr1_hscan(scr1_hscan), .scr2_hscan(scr2_hscan),
        .vram_dout(ram_q), .rom_data(rom_data),
        .scan_req(scan_req), .scan_addr(scan_addr), .scan_slot(scan_slot),
        .rom_addr(rom_addr), .scr_start(scr_start),
        .rowscr1(rowscr1), .rowscr2(rowscr2),
        .colscr1(colscr1), .colscr2(colscr2),
        .col_busy1(col_busy1), .col_busy2(col_busy2),
        .pxl(pxl)
    );

endmodule

`default_nettype wire

//--- testbench/char_subsys_tb.sv
//####################################################################
// Testbench for the character layer subsystem
// CPU accesses come from a table, the graphics ROM is modelled here,
// scroll latches and tile pixels are checked with and without flip
//####################################################################
`timescale 1ns/10ps
`default_nettype none
`include "char_params.svh"

module char_subsys_tb;
    import video_pkg::*;

    localparam int FRAME_CLKS = `CHAR_H_TOTAL * `CHAR_V_TOTAL * 4 + 64;  // Clocks per frame
    localparam logic [4:0] ROW_GROUP = 5'd3;    // Row scroll line group under test
    localparam logic [8:0] HSCAN1    = 9'h0a7;
    localparam logic [8:0] HSCAN2    = 9'h13f;
    localparam int TILE_T    = 8;               // Screen column of the test tile
    localparam int TILE_ROW  = 13;
    localparam int TILE_LINE = 3;               // Line inside the tile

    typedef struct packed {
        logic        wr;
        logic        sync;      // Start on a scan cycle
        logic [1:0]  be;
        logic [10:0] addr;
        logic [15:0] data;
        logic [15:0] rd_exp;
    } access_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        char_cs;
    logic [11:1] addr;
    logic [15:0] din;
    logic [1:0]  dsn;
    logic [15:0] dout;
    logic        ok;
    logic        flip;
    logic [8:0]  scr1_hscan;
    logic [8:0]  scr2_hscan;
    logic [12:0] rom_addr;
    logic [23:0] rom_data;
    logic [8:0]  hdump;
    logic [8:0]  vdump;
    char_pxl_t   pxl;
    logic        scr_start;
    logic [9:0]  rowscr1;
    logic [9:0]  rowscr2;
    logic [8:0]  colscr1;
    logic [8:0]  colscr2;
    logic        col_busy1;
    logic        col_busy2;
    logic        hblank;
    access_t     tab [0:15];
    int          rows;
    int          errors;
    integer      seed;

    char_subsys_top char_subsys_top_i (
        .clk(clk), .rst(rst), .char_cs(char_cs), .addr(addr), .din(din), .dsn(dsn),
        .dout(dout), .ok(ok), .flip(flip), .scr1_hscan(scr1_hscan), .scr2_hscan(scr2_hscan),
        .rom_addr(rom_addr), .rom_data(rom_data), .hdump(hdump), .vdump(vdump), .pxl(pxl),
        .scr_start(scr_start), .rowscr1(rowscr1), .rowscr2(rowscr2), .colscr1(colscr1),
        .colscr2(colscr2), .col_busy1(col_busy1), .col_busy2(col_busy2), .hblank(hblank)
    );

    always #10 clk = ~clk;    // 20 ns period

    // Graphics ROM, each plane a different mix of the address
    function automatic logic [23:0] rom_pattern(input logic [12:0] a);
        logic [7:0] p2;
        logic [7:0] p1;
        logic [7:0] p0;
        p2 = a[8:1] ^ 8'h3c;
        p1 = {a[12:9], a[4:1]} ^ 8'hc5;
        p0 = a[7:0] + {3'd0, a[12:8]};
        return {p2, p1, p0};
    endfunction

    always @(posedge clk)
        rom_data <= #2 rom_pattern(rom_addr);    // One clock of ROM latency

    // Attribute on top, then one bit of each plane
    function automatic logic [6:0] expected_pixel(input logic [3:0] attr,
                                                  input logic [23:0] planes, input int idx);
        return {attr, planes[16 + idx], planes[8 + idx], planes[idx]};
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on a timeout");
    endtask

    task automatic add_row(input logic wr, input logic sync, input logic [1:0] be,
                           input logic [10:0] a, input logic [15:0] d, input logic [15:0] e);
        tab[rows] = {wr, sync, be, a, d, e};
        rows++;
    endtask

    // Leaves the clock just before a pxl_cen cycle
    task automatic align_to_scan();
        logic [8:0] h0;
        int         n;
        @(negedge clk);
        h0 = hdump;
        n  = 0;
        while (hdump == h0) begin    // Step seen in first clock of a pixel
            n++;
            if (n > 8)
                timed_out("a step of the pixel counter");
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic cpu_access(input logic wr, input logic sync, input logic [10:0] a,
                              input logic [15:0] d, input logic [1:0] be,
                              output logic [15:0] rdata);
        int lat;
        if (sync)
            align_to_scan();
        @(posedge clk);
        #2;
        char_cs = 1'b1;
        addr    = a;
        din     = d;
        dsn     = wr ? ~be : 2'b11;    // No lane strobe on a read
        lat     = 0;
        @(negedge clk);
        while (!ok) begin
            lat++;
            if (lat > 20)
                timed_out("ok after a CPU access");
            @(negedge clk);
        end
        rdata = dout;
        check_value(lat <= 4, 1, "ok within 4 clocks of char_cs");
        @(posedge clk);
        #2;
        char_cs = 1'b0;
        dsn     = 2'b11;
        @(negedge clk);
        check_value(ok, 0, "single ok pulse");
        @(negedge clk);
        check_value(ok, 0, "single ok pulse");
    endtask

    task automatic wait_position(input logic [8:0] v, input logic [8:0] h, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!(vdump == v && hdump == h)) begin
            n++;
            if (n > FRAME_CLKS)
                timed_out(what);
            @(negedge clk);
        end
    endtask

    task automatic wait_scr_start(input logic [8:0] v);
        int n;
        n = 0;
        @(negedge clk);
        while (!(vdump == v && scr_start)) begin
            n++;
            if (n > FRAME_CLKS)
                timed_out("scr_start on the row scroll test line");
            @(negedge clk);
        end
    endtask

    task automatic wait_col_busy(input logic layer);
        int n;
        n = 0;
        @(negedge clk);
        while (!(layer ? col_busy2 : col_busy1)) begin
            n++;
            if (n > 100)
                timed_out(layer ? "col_busy2 pulse" : "col_busy1 pulse");
            @(negedge clk);
        end
    endtask

    // Eight pixels of the test tile, bit order set by flip
    task automatic check_tile(input logic flipped, input logic [8:0] v, input logic [8:0] start,
                              input logic [7:0] code, input logic [3:0] attr);
        logic [23:0] planes;
        int          k;
        planes = rom_pattern({1'b0, code, 3'(TILE_LINE), 1'b0});
        for (k = 0; k < 8; k++) begin
            wait_position(v, start + 9'(k), "a tile pixel position");
            check_value(pxl, expected_pixel(attr, planes, flipped ? k : 7 - k), "tile pixel");
        end
    endtask

    // Blanking around the end of the visible part of a line
    task automatic hblank_edges(input logic [8:0] v);
        wait_position(v, 9'(`CHAR_H_ACTIVE - 1), "the last visible pixel");
        check_value(hblank, 0, "hblank on the last visible pixel");
        wait_position(v, 9'(`CHAR_H_ACTIVE), "the first blanked pixel");
        check_value(hblank, 1, "hblank on the first blanked pixel");
        wait_position(v, 9'(`CHAR_H_TOTAL - 1), "the last pixel of a line");
        check_value(hblank, 1, "hblank on the last pixel of a line");
        wait_position(9'(v + 9'd1), 9'd0, "the start of the next line");
        check_value(hblank, 0, "hblank on the first pixel of a line");
    endtask

    initial begin
        int          i;
        logic [15:0] rdata;
        logic [15:0] rnd;
        logic [15:0] row1;
        logic [15:0] row2;
        logic [15:0] col1;
        logic [15:0] col2;
        logic [15:0] tile;
        logic [8:0]  inc;
        logic [10:0] tile_addr;
        logic [8:0]  start;
        seed       = 32'h32c4;
        errors     = 0;
        rows       = 0;
        rst        = 1'b1;
        char_cs    = 1'b0;
        addr       = '0;
        din        = '0;
        dsn        = 2'b11;
        flip       = 1'b0;
        scr1_hscan = '0;
        scr2_hscan = '0;
        rom_data   = '0;
        rnd        = 16'($random(seed));
        // Byte lanes, scan collisions and readback
        add_row(1, 0, 2'b11, 11'h123, 16'ha55a, 16'h0000);
        add_row(0, 0, 2'b00, 11'h123, 16'h0000, 16'ha55a);
        add_row(1, 0, 2'b01, 11'h123, 16'h1234, 16'h0000);
        add_row(0, 0, 2'b00, 11'h123, 16'h0000, 16'ha534);    // High lane kept
        add_row(1, 1, 2'b10, 11'h123, 16'hbeef, 16'h0000);
        add_row(0, 1, 2'b00, 11'h123, 16'h0000, 16'hbe34);
        add_row(1, 1, 2'b11, 11'h2c5, 16'h0f0f, 16'h0000);
        add_row(1, 1, 2'b10, 11'h2c5, 16'h7700, 16'h0000);
        add_row(0, 1, 2'b00, 11'h2c5, 16'h0000, 16'h770f);
        add_row(1, 0, 2'b11, 11'h3f0, rnd, 16'h0000);
        add_row(0, 1, 2'b00, 11'h3f0, 16'h0000, rnd);
        add_row(0, 0, 2'b00, 11'h123, 16'h0000, 16'hbe34);
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        for (i = 0; i < rows; i++) begin
            cpu_access(tab[i].wr, tab[i].sync, tab[i].addr, tab[i].data, tab[i].be, rdata);
            if (!tab[i].wr)
                check_value(rdata, tab[i].rd_exp, "CPU readback");
        end
        // Row scroll, vrender of line 8g+2 falls in group g
        row1 = 16'($random(seed));
        row2 = 16'($random(seed));
        cpu_access(1, 0, {`CHAR_ROWSCR_BASE, ROW_GROUP, 1'b0}, row1, 2'b11, rdata);
        cpu_access(1, 0, {`CHAR_ROWSCR_BASE, ROW_GROUP, 1'b1}, row2, 2'b11, rdata);
        wait_scr_start(9'(8 * ROW_GROUP + 2));
        check_value(rowscr1, row1[9:0], "rowscr1");
        check_value(rowscr2, row2[9:0], "rowscr2");
        // Column scroll indexed by incremented hscan bits 8 to 4
        @(posedge clk);
        #2;
        scr1_hscan = HSCAN1;
        scr2_hscan = HSCAN2;
        col1 = 16'($random(seed));
        col2 = 16'($random(seed));
        inc  = HSCAN1 + 9'd1;
        cpu_access(1, 0, {`CHAR_COLSCR_BASE, inc[8:4], 1'b0}, col1, 2'b11, rdata);
        inc  = HSCAN2 + 9'd1;
        cpu_access(1, 1, {`CHAR_COLSCR_BASE, inc[8:4], 1'b1}, col2, 2'b11, rdata);
        wait_col_busy(1'b0);
        check_value(colscr1, col1[8:0], "colscr1");
        wait_col_busy(1'b1);
        check_value(colscr2, col2[8:0], "colscr2");
        // Tile entry is fetched LAG/8 columns ahead of its screen column
        tile      = 16'($random(seed)) & 16'h0fff;
        tile_addr = {5'(TILE_ROW), 6'(TILE_T + `CHAR_PXL_LAG / 8)};
        cpu_access(1, 0, tile_addr, tile, 2'b11, rdata);
        start = 9'(8 * TILE_T + `CHAR_PXL_LAG);
        check_tile(1'b0, 9'(8 * TILE_ROW + TILE_LINE), start, tile[7:0], tile[11:8]);
        @(posedge clk);
        #2;
        flip = 1'b1;
        // Fetch pixel whose mirrored position lands in column t
        start = 9'(((`CHAR_FLIP_OFFSET - 7) & ~7) - 8 * TILE_T + `CHAR_PXL_LAG);
        check_tile(1'b1, 9'(`CHAR_V_ACTIVE - 1 - (8 * TILE_ROW + TILE_LINE)), start,
                   tile[7:0], tile[11:8]);
        hblank_edges(vdump);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
hdl/video_pkg.sv
hdl/vram_bus_pkg.sv
hdl/video_timing.sv
hdl/char_vram.sv
hdl/vram_arbiter.sv
hdl/cpu_vram_port.sv
hdl/char_scan.sv
hdl/char_subsys_top.sv
testbench/char_subsys_tb.sv

//--- Bender.yml
package:
  name: char_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/video_pkg.sv
      - hdl/vram_bus_pkg.sv
      - hdl/video_timing.sv
      - hdl/char_vram.sv
      - hdl/vram_arbiter.sv
      - hdl/cpu_vram_port.sv
      - hdl/char_scan.sv
      - hdl/char_subsys_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/char_subsys_tb.sv
